/* compile.f */
hw/qla_pkg.sv
hw/rt_write_unpack.sv
hw/safety_check.sv
hw/motor_regs.sv
hw/bus_ctrl.sv
hw/qla_core.sv
verif/tb_clock_gen.sv
verif/qla_core_assertions.sv
verif/tb_qla_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the qla core testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_qla_core \
    -f compile.f \
    -o sim_qla_core

./obj_dir/sim_qla_core > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* verif/tb_qla_core.sv */
//----------------------------------------
// qla core testbench
// table of host, rt block, feedback and
// dac operations, with a dac ack responder
//----------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tb_qla_core import qla_pkg::*; ();

    localparam int OP_WR    = 0;  // host write, flag = block write
    localparam int OP_RD    = 1;  // host read with expected word
    localparam int OP_RT    = 2;  // four-word rt block
    localparam int OP_FB    = 3;  // set measured currents
    localparam int OP_WAIT  = 4;
    localparam int OP_PINS  = 5;
    localparam int OP_DAC   = 6;  // expect one transfer, flag = check latency
    localparam int OP_NODAC = 7;  // no req and nothing pending in the monitor

    localparam int DAC_WAIT_MAX = 32;

    // ch4 .. ch1 packed, same order as dac_data
    localparam logic [63:0] HOST_CMDS = {16'h6f00, 16'h9000, 16'h7abc, 16'h8123};
    localparam logic [63:0] RT_CMDS   = {16'h7600, 16'h8a00, 16'h7c00, 16'h8400};
    localparam logic [63:0] BLK_CMDS  = {16'h7600, 16'h8800, 16'h7c00, 16'h8400};
    localparam logic [63:0] FB_MID    = {16'h8000, 16'h8000, 16'h8000, 16'h8000};
    // ch2 cmd 7c00 -> limit 0c00, 9000 is 1000 out
    localparam logic [63:0] FB_TRIP   = {16'h8000, 16'h8000, 16'h9000, 16'h8000};
    // ch3 cmd 8800 -> limit 1400, 9300 is only 1300 out
    localparam logic [63:0] FB_CH3    = {16'h8000, 16'h9300, 16'h9000, 16'h8000};
    localparam logic [63:0] FB_BACK   = {16'h8000, 16'h9300, 16'h8800, 16'h8000};

    logic                sysclk;
    logic                rst;
    logic                fw_reg_wen;
    addr_t               fw_reg_waddr;
    data_t               fw_reg_wdata;
    logic                fw_blk_wen;
    addr_t               reg_raddr;
    data_t               reg_rdata;
    logic                rt_wen;
    logic [1:0]          rt_waddr;
    cur_t                rt_wdata;
    cur_t [NUM_CHAN-1:0] cur_fb;
    logic                dac_req;
    logic                dac_ack;
    cur_t [NUM_CHAN-1:0] dac_data;
    chan_mask_t          amp_disable_pin;

    // operation table
    int          op_kind [$];
    addr_t       op_addr [$];
    logic [63:0] op_data [$];
    logic [63:0] op_exp  [$];
    logic        op_flag [$];
    string       op_name [$];

    logic [63:0] xfer_data [$];  // dac_data at each req rise
    int          xfer_cyc  [$];
    int          cyc = 0;
    int          cycle_limit = 1000000;  // replaced once the table is built
    int          last_write_cyc;
    int          errors;
    integer      seed;

    tb_clock_gen i_clock_gen (
        .sysclk (sysclk),
        .rst    (rst)
    );

    qla_core i_dut (
        .sysclk          (sysclk),
        .rst             (rst),
        .fw_reg_wen      (fw_reg_wen),
        .fw_reg_waddr    (fw_reg_waddr),
        .fw_reg_wdata    (fw_reg_wdata),
        .fw_blk_wen      (fw_blk_wen),
        .reg_raddr       (reg_raddr),
        .reg_rdata       (reg_rdata),
        .rt_wen          (rt_wen),
        .rt_waddr        (rt_waddr),
        .rt_wdata        (rt_wdata),
        .cur_fb          (cur_fb),
        .dac_req         (dac_req),
        .dac_ack         (dac_ack),
        .dac_data        (dac_data),
        .amp_disable_pin (amp_disable_pin)
    );

    //----------------------------------------
    // helpers
    //----------------------------------------
    function automatic addr_t reg_addr(input logic [3:0] space, input logic [3:0] chan,
                                       input logic [3:0] off);
        return {space, 4'd0, chan, off};
    endfunction

    function automatic int op_cost(input int kind, input logic [63:0] data);
        case (kind)
            OP_RT:   return RT_WORDS;
            OP_WAIT: return int'(data[15:0]);
            OP_DAC:  return DAC_WAIT_MAX;
            default: return 1;
        endcase
    endfunction

    task automatic add_op(input int kind, input addr_t addr, input logic [63:0] data,
                          input logic [63:0] exp, input logic flag, input string name);
        op_kind.push_back(kind);
        op_addr.push_back(addr);
        op_data.push_back(data);
        op_exp.push_back(exp);
        op_flag.push_back(flag);
        op_name.push_back(name);
    endtask

    task automatic check_equal(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge sysclk);
            #10;
        end
    endtask

    task automatic host_write(input addr_t addr, input data_t data, input logic blk);
        fw_reg_waddr   = addr;
        fw_reg_wdata   = data;
        fw_blk_wen     = blk;
        fw_reg_wen     = 1'b1;
        last_write_cyc = cyc;  // strobe cycle for the latency check
        wait_cycles(1);
        fw_reg_wen     = 1'b0;
        fw_blk_wen     = 1'b0;
    endtask

    task automatic host_read(input string name, input addr_t addr, input logic [63:0] exp);
        reg_raddr = addr;
        wait_cycles(1);  // rdata registered one cycle on
        check_equal(name, exp, {32'd0, reg_rdata});
    endtask

    task automatic rt_block(input logic [63:0] words);
        for (int k = 0; k < RT_WORDS; k++) begin
            rt_wen   = 1'b1;
            rt_waddr = 2'(k);
            rt_wdata = words[16*k +: 16];
            wait_cycles(1);
        end
        rt_wen = 1'b0;
    endtask

    task automatic expect_transfer(input string name, input logic [63:0] exp, input logic lat);
        int          n;
        logic [63:0] got;
        int          rise;
        n = 0;
        while (xfer_data.size() == 0 && n < DAC_WAIT_MAX) begin
            wait_cycles(1);
            n++;
        end
        if (xfer_data.size() == 0) begin
            $display("no DAC transfer within %0d cycles in %s", DAC_WAIT_MAX, name);
            $display("TEST FAIL");
            $fatal(1, "dac transfer missing");
        end else begin
            got  = xfer_data.pop_front();
            rise = xfer_cyc.pop_front();
            check_equal(name, exp, got);
            if (lat) begin
                check_equal({name, " latency"}, 64'd2, 64'(rise - last_write_cyc));
            end
        end
    endtask

    task automatic run_op(input int i);
        case (op_kind[i])
            OP_WR:   host_write(op_addr[i], op_data[i][31:0], op_flag[i]);
            OP_RD:   host_read(op_name[i], op_addr[i], op_exp[i]);
            OP_RT:   rt_block(op_data[i]);
            OP_FB:   cur_fb = op_data[i];
            OP_WAIT: wait_cycles(int'(op_data[i][15:0]));
            OP_PINS: check_equal(op_name[i], op_exp[i], {60'd0, amp_disable_pin});
            OP_DAC:  expect_transfer(op_name[i], op_exp[i], op_flag[i]);
            default: begin
                check_equal({op_name[i], " req"}, 64'd0, {63'd0, dac_req});
                check_equal({op_name[i], " count"}, 64'd0, 64'(xfer_data.size()));
            end
        endcase
    endtask

    //----------------------------------------
    // operation table
    //----------------------------------------
    task automatic build_table();
        add_op(OP_PINS, 16'h0, 64'd0, 64'hf, 1'b0, "reset pins");
        add_op(OP_NODAC, 16'h0, 64'd0, 64'd0, 1'b0, "reset dac idle");
        for (int k = 1; k <= NUM_CHAN; k++) begin
            add_op(OP_RD, reg_addr(ADDR_MAIN, 4'(k), OFF_MOTOR_STATUS), 64'd0, 64'd1, 1'b0,
                   $sformatf("reset status ch%0d", k));
            add_op(OP_RD, reg_addr(ADDR_MAIN, 4'(k), OFF_DAC_CTRL), 64'd0, 64'(CUR_MID), 1'b0,
                   $sformatf("reset cmd ch%0d", k));
        end
        // plain host writes read back, no dac update
        for (int k = 1; k <= NUM_CHAN; k++) begin
            add_op(OP_WR, reg_addr(ADDR_MAIN, 4'(k), OFF_DAC_CTRL),
                   64'(HOST_CMDS[16*(k-1) +: 16]), 64'd0, 1'b0, "host cmd");
        end
        for (int k = 1; k <= NUM_CHAN; k++) begin
            add_op(OP_RD, reg_addr(ADDR_MAIN, 4'(k), OFF_DAC_CTRL), 64'd0,
                   64'(HOST_CMDS[16*(k-1) +: 16]), 1'b0, $sformatf("host cmd ch%0d", k));
        end
        add_op(OP_WAIT, 16'h0, 64'd4, 64'd0, 1'b0, "settle");
        add_op(OP_NODAC, 16'h0, 64'd0, 64'd0, 1'b0, "host write no dac");
        add_op(OP_RD, reg_addr(ADDR_MAIN, 4'd0, OFF_DAC_CTRL), 64'd0, 64'd0, 1'b0, "chan 0");
        add_op(OP_RD, reg_addr(ADDR_MAIN, 4'd5, OFF_DAC_CTRL), 64'd0, 64'd0, 1'b0, "chan 5");
        add_op(OP_RD, reg_addr(4'd1, 4'd1, OFF_DAC_CTRL), 64'd0, 64'd0, 1'b0, "space 1");
        // rt block -> four writes, one merged transfer
        add_op(OP_RT, 16'h0, RT_CMDS, 64'd0, 1'b0, "rt block");
        add_op(OP_DAC, 16'h0, 64'd0, RT_CMDS, 1'b0, "rt dac data");
        for (int k = 1; k <= NUM_CHAN; k++) begin
            add_op(OP_RD, reg_addr(ADDR_MAIN, 4'(k), OFF_DAC_CTRL), 64'd0,
                   64'(RT_CMDS[16*(k-1) +: 16]), 1'b0, $sformatf("rt cmd ch%0d", k));
        end
        add_op(OP_WAIT, 16'h0, 64'd8, 64'd0, 1'b0, "settle");
        add_op(OP_NODAC, 16'h0, 64'd0, 64'd0, 1'b0, "rt single transfer");
        // block-flagged host write, req 2 cycles on
        add_op(OP_WR, reg_addr(ADDR_MAIN, 4'd3, OFF_DAC_CTRL), 64'h8800, 64'd0, 1'b1, "blk");
        add_op(OP_DAC, 16'h0, 64'd0, BLK_CMDS, 1'b1, "blk dac data");
        add_op(OP_WAIT, 16'h0, 64'd10, 64'd0, 1'b0, "settle");
        add_op(OP_NODAC, 16'h0, 64'd0, 64'd0, 1'b0, "blk single transfer");
        // ch2 overcurrent trip
        add_op(OP_WR, reg_addr(ADDR_MAIN, 4'd2, OFF_MOTOR_STATUS), 64'd1, 64'd0, 1'b0, "en 2");
        add_op(OP_WAIT, 16'h0, 64'd2, 64'd0, 1'b0, "settle");
        add_op(OP_PINS, 16'h0, 64'd0, 64'hd, 1'b0, "ch2 enabled pins");
        add_op(OP_FB, 16'h0, FB_TRIP, 64'd0, 1'b0, "fb trip");
        add_op(OP_WAIT, 16'h0, 64'd20, 64'd0, 1'b0, "hold over limit");
        add_op(OP_PINS, 16'h0, 64'd0, 64'hf, 1'b0, "ch2 tripped pins");
        add_op(OP_RD, reg_addr(ADDR_MAIN, 4'd2, OFF_MOTOR_STATUS), 64'd0, 64'h6, 1'b0,
               "ch2 tripped status");
        // ch3 inside its limit stays on
        add_op(OP_WR, reg_addr(ADDR_MAIN, 4'd3, OFF_MOTOR_STATUS), 64'd1, 64'd0, 1'b0, "en 3");
        add_op(OP_FB, 16'h0, FB_CH3, 64'd0, 1'b0, "fb ch3");
        add_op(OP_WAIT, 16'h0, 64'd40, 64'd0, 1'b0, "hold in limit");
        add_op(OP_PINS, 16'h0, 64'd0, 64'hb, 1'b0, "ch3 enabled pins");
        add_op(OP_RD, reg_addr(ADDR_MAIN, 4'd3, OFF_MOTOR_STATUS), 64'd0, 64'd0, 1'b0,
               "ch3 status");
        add_op(OP_RD, reg_addr(ADDR_MAIN, 4'd3, OFF_ADC_DATA), 64'd0, 64'h9300, 1'b0,
               "ch3 adc");
        // re-enable clears the ch2 latch
        add_op(OP_FB, 16'h0, FB_BACK, 64'd0, 1'b0, "fb back");
        add_op(OP_WR, reg_addr(ADDR_MAIN, 4'd2, OFF_MOTOR_STATUS), 64'd1, 64'd0, 1'b0, "en 2");
        add_op(OP_WAIT, 16'h0, 64'd2, 64'd0, 1'b0, "settle");
        add_op(OP_PINS, 16'h0, 64'd0, 64'h9, 1'b0, "ch2 cleared pins");
        add_op(OP_RD, reg_addr(ADDR_MAIN, 4'd2, OFF_MOTOR_STATUS), 64'd0, 64'd0, 1'b0,
               "ch2 cleared status");
        add_op(OP_WAIT, 16'h0, 64'd20, 64'd0, 1'b0, "hold in limit");
        add_op(OP_PINS, 16'h0, 64'd0, 64'h9, 1'b0, "ch2 stays on");
    endtask

    //----------------------------------------
    // dac side: ack responder and monitor
    //----------------------------------------
    initial begin : ack_responder
        int dly;
        seed    = 32'h8c60_2f37;
        dac_ack = 1'b0;
        forever begin
            wait_cycles(1);
            if (dac_req && !dac_ack) begin
                dly = int'($unsigned($random(seed)) % 32'd5);  // 0..4 cycles
                wait_cycles(dly);
                dac_ack = 1'b1;
                while (dac_req) begin
                    wait_cycles(1);
                end
                dac_ack = 1'b0;  // req seen low, close the handshake
            end
        end
    end

    initial begin : xfer_monitor
        logic req_prev;
        req_prev = 1'b0;
        forever begin
            @(posedge sysclk);
            #5;  // ahead of the op checks at +10
            if (!rst && dac_req && !req_prev) begin
                xfer_data.push_back(dac_data);
                xfer_cyc.push_back(cyc);
            end
            req_prev = dac_req;
        end
    end

    // cycle count and run limit
    always @(posedge sysclk) begin
        cyc <= cyc + 1;
        if (cyc > cycle_limit) begin
            $display("timeout: run passed %0d cycles without finishing", cycle_limit);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    //----------------------------------------
    // main sequence
    //----------------------------------------
    initial begin
        int total;
        fw_reg_wen     = 1'b0;
        fw_reg_waddr   = '0;
        fw_reg_wdata   = '0;
        fw_blk_wen     = 1'b0;
        reg_raddr      = '0;
        rt_wen         = 1'b0;
        rt_waddr       = 2'd0;
        rt_wdata       = '0;
        cur_fb         = FB_MID;
        errors         = 0;
        last_write_cyc = 0;

        build_table();
        total = 10;  // reset and start-up
        foreach (op_kind[i]) begin
            total += op_cost(op_kind[i], op_data[i]);
        end
        cycle_limit = 2 * total;

        wait (rst == 1'b0);
        wait_cycles(1);
        for (int i = 0; i < op_kind.size(); i++) begin
            run_op(i);
        end

        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/qla_core_assertions.sv */
//----------------------------------------
// qla core assertions
// dac four-phase handshake and safety pin
//----------------------------------------

`timescale 1ns/1ns
`default_nettype none

module qla_core_assertions import qla_pkg::*; (
    input wire logic       sysclk,
    input wire logic       rst,
    input wire logic       dac_req,
    input wire logic       dac_ack,
    input wire chan_mask_t safety_disable,
    input wire chan_mask_t amp_disable_pin
);

    // req stays up until the controller answers
    a_req_hold: assert property (@(posedge sysclk) disable iff (rst)
        (dac_req && !dac_ack) |=> dac_req)
        else $error("dac_req dropped before dac_ack");

    // no new request while ack is still high
    a_req_rise: assert property (@(posedge sysclk) disable iff (rst)
        (!dac_req && dac_ack) |=> !dac_req)
        else $error("dac_req raised while dac_ack high");

    // tripped channel must show a disabled pin one cycle on
    a_trip_pin: assert property (@(posedge sysclk) disable iff (rst)
        (safety_disable != '0) |=>
        ((amp_disable_pin & $past(safety_disable)) == $past(safety_disable)))
        else $error("safety latch set but amplifier pin enabled");

endmodule

// handshake side, safety inputs tied off
bind bus_ctrl qla_core_assertions i_hs_assertions (
    .sysclk          (sysclk),
    .rst             (rst),
    .dac_req         (dac_req),
    .dac_ack         (dac_ack),
    .safety_disable  (4'b0000),
    .amp_disable_pin (4'b1111)
);

// safety side, handshake tied idle
bind motor_regs qla_core_assertions i_safety_assertions (
    .sysclk          (sysclk),
    .rst             (rst),
    .dac_req         (1'b0),
    .dac_ack         (1'b0),
    .safety_disable  (safety_disable),
    .amp_disable_pin (amp_disable_pin)
);

`default_nettype wire

/* verif/tb_clock_gen.sv */
//----------------------------------------
// testbench clock and reset
// 100 ns sysclk, rst high for 4 cycles
//----------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic sysclk,
    output logic rst
);

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;  // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge sysclk);
        #10;
        rst = 1'b0;  // released off the edge, like other inputs
    end

endmodule

`default_nettype wire

/* hw/qla_core.sv */
//--------------------------------------
// qla core top
// register bus, motor regs, dac link and
// safety check of the four-axis board
//--------------------------------------

`timescale 1ns/1ns
`default_nettype none

module qla_core import qla_pkg::*; (
    input  wire logic                  sysclk,
    input  wire logic                  rst,
    // host write bus
    input  wire logic                  fw_reg_wen,
    input  wire addr_t                 fw_reg_waddr,
    input  wire data_t                 fw_reg_wdata,
    input  wire logic                  fw_blk_wen,
    // host read
    input  wire addr_t                 reg_raddr,
    output data_t                      reg_rdata,
    // real-time block port
    input  wire logic                  rt_wen,
    input  wire logic [1:0]            rt_waddr,
    input  wire cur_t                  rt_wdata,
    // measured currents
    input  wire cur_t [NUM_CHAN-1:0]   cur_fb,
    // dac controller link
    output logic                       dac_req,
    input  wire logic                  dac_ack,
    output cur_t [NUM_CHAN-1:0]        dac_data,
    // amplifier pins
    output chan_mask_t                 amp_disable_pin
);

    // block write bus from the rt unpacker
    logic                bw_write_en;
    logic                bw_reg_wen;
    addr_t               bw_reg_waddr;
    data_t               bw_reg_wdata;
    logic                bw_blk_wen;

    // decoded register writes
    logic                cmd_wen;
    logic                amp_wen;
    chan_t               wchan;
    data_t               wdata;
    logic                dac_load;       // snapshot commands for the dac

    cur_t [NUM_CHAN-1:0] cur_cmd;
    chan_mask_t          amp_disable;    // host side disable
    chan_mask_t          safety_disable; // overcurrent latches

    bus_ctrl i_bus_ctrl (
        .sysclk         (sysclk),
        .rst            (rst),
        .fw_reg_wen     (fw_reg_wen),
        .fw_reg_waddr   (fw_reg_waddr),
        .fw_reg_wdata   (fw_reg_wdata),
        .fw_blk_wen     (fw_blk_wen),
        .bw_write_en    (bw_write_en),
        .bw_reg_wen     (bw_reg_wen),
        .bw_reg_waddr   (bw_reg_waddr),
        .bw_reg_wdata   (bw_reg_wdata),
        .bw_blk_wen     (bw_blk_wen),
        .reg_raddr      (reg_raddr),
        .cur_fb         (cur_fb),
        .cur_cmd        (cur_cmd),
        .amp_disable    (amp_disable),
        .safety_disable (safety_disable),
        .dac_ack        (dac_ack),
        .cmd_wen        (cmd_wen),
        .amp_wen        (amp_wen),
        .wchan          (wchan),
        .wdata          (wdata),
        .dac_load       (dac_load),
        .dac_req        (dac_req),
        .reg_rdata      (reg_rdata)
    );

    rt_write_unpack i_rt_write_unpack (
        .sysclk       (sysclk),
        .rst          (rst),
        .rt_wen       (rt_wen),
        .rt_waddr     (rt_waddr),
        .rt_wdata     (rt_wdata),
        .bw_write_en  (bw_write_en),
        .bw_reg_wen   (bw_reg_wen),
        .bw_reg_waddr (bw_reg_waddr),
        .bw_reg_wdata (bw_reg_wdata),
        .bw_blk_wen   (bw_blk_wen)
    );

    motor_regs i_motor_regs (
        .sysclk          (sysclk),
        .rst             (rst),
        .cmd_wen         (cmd_wen),
        .amp_wen         (amp_wen),
        .wchan           (wchan),
        .wdata           (wdata),
        .dac_load        (dac_load),
        .safety_disable  (safety_disable),
        .cur_cmd         (cur_cmd),
        .amp_disable     (amp_disable),
        .dac_data        (dac_data),
        .amp_disable_pin (amp_disable_pin)
    );

    safety_check i_safety_check (
        .sysclk         (sysclk),
        .rst            (rst),
        .cur_fb         (cur_fb),
        .cur_cmd        (cur_cmd),
        .amp_disable    (amp_disable),
        .amp_wen        (amp_wen),
        .wchan          (wchan),
        .wdata          (wdata),
        .safety_disable (safety_disable)
    );

endmodule

`default_nettype wire

/* hw/bus_ctrl.sv */
//--------------------------------------
// bus control
// write bus select and decode, dac
// handshake FSM, registered read mux
//--------------------------------------

`timescale 1ns/1ns
`default_nettype none

module bus_ctrl import qla_pkg::*; (
    input  wire logic                sysclk,
    input  wire logic                rst,
    input  wire logic                fw_reg_wen,
    input  wire addr_t               fw_reg_waddr,
    input  wire data_t               fw_reg_wdata,
    input  wire logic                fw_blk_wen,
    input  wire logic                bw_write_en,   // rt block owns the bus
    input  wire logic                bw_reg_wen,
    input  wire addr_t               bw_reg_waddr,
    input  wire data_t               bw_reg_wdata,
    input  wire logic                bw_blk_wen,
    input  wire addr_t               reg_raddr,
    input  wire cur_t [NUM_CHAN-1:0] cur_fb,
    input  wire cur_t [NUM_CHAN-1:0] cur_cmd,
    input  wire chan_mask_t          amp_disable,
    input  wire chan_mask_t          safety_disable,
    input  wire logic                dac_ack,
    output logic                     cmd_wen,
    output logic                     amp_wen,
    output chan_t                    wchan,
    output data_t                    wdata,
    output logic                     dac_load,
    output logic                     dac_req,
    output data_t                    reg_rdata
);

    typedef enum logic [1:0] {DAC_IDLE, DAC_REQ, DAC_WAIT_LOW} dac_state_t;

    logic       reg_wen;
    addr_t      reg_waddr;
    logic       blk_wen;
    logic       wr_hit;      // main space, channel 1..4
    logic       pending;     // one merged dac update waiting
    dac_state_t state;
    logic       rd_hit;
    logic [1:0] rd_idx;      // channel 1..4 -> 0..3
    data_t      rd_word;

    //--------------------------------------
    // write bus select and decode
    //--------------------------------------
    always_comb begin
        if (bw_write_en) begin
            reg_wen   = bw_reg_wen;
            reg_waddr = bw_reg_waddr;
            wdata     = bw_reg_wdata;
            blk_wen   = bw_blk_wen;
        end else begin
            reg_wen   = fw_reg_wen;
            reg_waddr = fw_reg_waddr;
            wdata     = fw_reg_wdata;
            blk_wen   = fw_blk_wen;
        end
    end

    assign wchan   = reg_waddr[7:4];
    assign wr_hit  = reg_wen && (reg_waddr[15:12] == ADDR_MAIN) &&
                     (wchan != 4'd0) && (wchan <= chan_t'(NUM_CHAN));
    assign cmd_wen = wr_hit && (reg_waddr[3:0] == OFF_DAC_CTRL);
    assign amp_wen = wr_hit && (reg_waddr[3:0] == OFF_MOTOR_STATUS);

    //--------------------------------------
    // dac handshake
    //--------------------------------------
    // hold off while a block replays so all four words go in one update
    assign dac_load = (state == DAC_IDLE) && pending && !bw_write_en && !dac_ack;
    assign dac_req  = (state == DAC_REQ);

    always_ff @(posedge sysclk) begin
        if (rst) begin
            state   <= DAC_IDLE;
            pending <= 1'b0;
        end else begin
            pending <= (cmd_wen && blk_wen) || (pending && !dac_load);
            case (state)
                DAC_IDLE:     if (dac_load) state <= DAC_REQ;
                DAC_REQ:      if (dac_ack) state <= DAC_WAIT_LOW;   // req drops next
                DAC_WAIT_LOW: if (!dac_ack) state <= DAC_IDLE;
                default:      state <= DAC_IDLE;
            endcase
        end
    end

    //--------------------------------------
    // read mux
    //--------------------------------------
    assign rd_idx = reg_raddr[5:4] - 2'd1;
    assign rd_hit = (reg_raddr[15:12] == ADDR_MAIN) && (reg_raddr[7:4] != 4'd0) &&
                    (reg_raddr[7:4] <= chan_t'(NUM_CHAN));

    always_comb begin
        rd_word = '0;
        if (rd_hit) begin
            case (reg_raddr[3:0])
                OFF_ADC_DATA: rd_word = {16'd0, cur_fb[rd_idx]};
                OFF_DAC_CTRL: rd_word = {16'd0, cur_cmd[rd_idx]};
                // bit 2 set when the trip alone holds the pin off
                OFF_MOTOR_STATUS: rd_word = {29'd0,
                                             safety_disable[rd_idx] & ~amp_disable[rd_idx],
                                             safety_disable[rd_idx],
                                             amp_disable[rd_idx]};
                default: rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        reg_rdata <= rd_word;  // one cycle read latency
    end

endmodule

`default_nettype wire

/* hw/motor_regs.sv */
//--------------------------------------
// motor channel registers
// current commands, amp disables, dac
// snapshot and amplifier pin drive
//--------------------------------------

`timescale 1ns/1ns
`default_nettype none

module motor_regs import qla_pkg::*; (
    input  wire logic       sysclk,
    input  wire logic       rst,
    input  wire logic       cmd_wen,
    input  wire logic       amp_wen,
    input  wire chan_t      wchan,
    input  wire data_t      wdata,
    input  wire logic       dac_load,
    input  wire chan_mask_t safety_disable,
    output cur_t [NUM_CHAN-1:0] cur_cmd,
    output chan_mask_t      amp_disable,
    output cur_t [NUM_CHAN-1:0] dac_data,
    output chan_mask_t      amp_disable_pin
);

    // command and enable registers
    always_ff @(posedge sysclk) begin
        if (rst) begin
            cur_cmd     <= {NUM_CHAN{CUR_MID}};  // zero current
            amp_disable <= '1;                   // all amps off
        end else begin
            for (int k = 0; k < NUM_CHAN; k++) begin
                if (cmd_wen && (wchan == chan_t'(k + 1))) begin
                    cur_cmd[k] <= wdata[15:0];
                end
                if (amp_wen && (wchan == chan_t'(k + 1))) begin
                    amp_disable[k] <= ~wdata[0];  // bit 0 = enable
                end
            end
        end
    end

    // frozen copy held for the whole handshake
    always_ff @(posedge sysclk) begin
        if (dac_load) begin
            dac_data <= cur_cmd;
        end
    end

    //--------------------------------------
    // amplifier pins
    //--------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            amp_disable_pin <= '1;
        end else begin
            amp_disable_pin <= amp_disable | safety_disable;  // either source kills the amp
        end
    end

endmodule

`default_nettype wire

/* hw/safety_check.sv */
//--------------------------------------
// overcurrent safety check
// trips a channel when |fb| stays above
// 2*|cmd| + margin for SAFETY_HOLD cycles
//--------------------------------------

`timescale 1ns/1ns
`default_nettype none

module safety_check import qla_pkg::*; (
    input  wire logic                sysclk,
    input  wire logic                rst,
    input  wire cur_t [NUM_CHAN-1:0] cur_fb,
    input  wire cur_t [NUM_CHAN-1:0] cur_cmd,
    input  wire chan_mask_t          amp_disable,
    input  wire logic                amp_wen,
    input  wire chan_t               wchan,
    input  wire data_t               wdata,
    output chan_mask_t               safety_disable
);

    cur_t              fb_dev  [NUM_CHAN];
    cur_t              cmd_dev [NUM_CHAN];
    logic [17:0]       limit   [NUM_CHAN];  // 2*cmd + margin, no overflow
    chan_mask_t        run;                 // over limit with amp enabled
    chan_mask_t        clear;               // enabling status write
    logic [HOLD_W-1:0] cnt     [NUM_CHAN];

    // distance from zero current
    function automatic cur_t dev_mid(cur_t v);
        return (v >= CUR_MID) ? v - CUR_MID : CUR_MID - v;
    endfunction

    always_comb begin
        for (int k = 0; k < NUM_CHAN; k++) begin
            fb_dev[k]  = dev_mid(cur_fb[k]);
            cmd_dev[k] = dev_mid(cur_cmd[k]);
            limit[k]   = {1'b0, cmd_dev[k], 1'b0} + {2'b00, SAFETY_MARGIN};
            run[k]     = ({2'b00, fb_dev[k]} > limit[k]) && !amp_disable[k];
            clear[k]   = amp_wen && wdata[0] && (wchan == chan_t'(k + 1));
        end
    end

    //--------------------------------------
    // persistence counters and latches
    //--------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            safety_disable <= '0;
            for (int k = 0; k < NUM_CHAN; k++) begin
                cnt[k] <= '0;
            end
        end else begin
            for (int k = 0; k < NUM_CHAN; k++) begin
                if (clear[k]) begin
                    safety_disable[k] <= 1'b0;
                    cnt[k]            <= '0;
                end else if (run[k]) begin
                    if (cnt[k] == HOLD_W'(SAFETY_HOLD - 1)) begin
                        safety_disable[k] <= 1'b1;  // sticks until re-enable
                    end else begin
                        cnt[k] <= cnt[k] + 1'b1;
                    end
                end else begin
                    cnt[k] <= '0;  // streak broken
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rt_write_unpack.sv */
//--------------------------------------
// real-time block unpacker
// buffers four command words and replays
// them as dac register writes, chan 1..4
//--------------------------------------

`timescale 1ns/1ns
`default_nettype none

module rt_write_unpack import qla_pkg::*; (
    input  wire logic       sysclk,
    input  wire logic       rst,
    input  wire logic       rt_wen,
    input  wire logic [1:0] rt_waddr,   // word index, word k -> chan k+1
    input  wire cur_t       rt_wdata,
    output logic            bw_write_en,
    output logic            bw_reg_wen,
    output addr_t           bw_reg_waddr,
    output data_t           bw_reg_wdata,
    output logic            bw_blk_wen
);

    cur_t       rt_buf [RT_WORDS];
    logic       busy;    // replay in progress
    logic [1:0] idx;     // replay word
    chan_t      rp_chan;

    always_ff @(posedge sysclk) begin
        if (rt_wen) begin
            rt_buf[rt_waddr] <= rt_wdata;
        end
    end

    //--------------------------------------
    // replay sequencer
    //--------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            busy <= 1'b0;
            idx  <= 2'd0;
        end else if (busy) begin
            idx <= idx + 2'd1;
            if (idx == 2'(RT_WORDS - 1)) begin
                busy <= 1'b0;  // four writes done
            end
        end else if (rt_wen && (rt_waddr == 2'(RT_WORDS - 1))) begin
            busy <= 1'b1;      // last word in, start next cycle
            idx  <= 2'd0;
        end
    end

    assign rp_chan = {2'b00, idx} + 4'd1;

    // one write per cycle, all flagged as block writes
    assign bw_write_en  = busy;
    assign bw_reg_wen   = busy;
    assign bw_blk_wen   = busy;
    assign bw_reg_waddr = {ADDR_MAIN, 4'd0, rp_chan, OFF_DAC_CTRL};
    assign bw_reg_wdata = {16'd0, rt_buf[idx]};

endmodule

`default_nettype wire

/* hw/qla_pkg.sv */
//--------------------------------------
// qla core package
// register map, safety limits, word types
//--------------------------------------

`default_nettype none

package qla_pkg;

    //--------------------------------------
    // word types
    //--------------------------------------
    typedef logic [15:0] addr_t;       // space 15:12, chan 7:4, offset 3:0
    typedef logic [31:0] data_t;
    typedef logic [15:0] cur_t;        // offset binary, 8000 is zero
    typedef logic [3:0]  chan_t;
    typedef logic [3:0]  chan_mask_t;  // bit 0 is channel 1

    //--------------------------------------
    // address map
    //--------------------------------------
    localparam int NUM_CHAN = 4;

    localparam logic [3:0] ADDR_MAIN        = 4'd0;  // only space decoded here
    localparam logic [3:0] OFF_ADC_DATA     = 4'd0;  // measured current, read only
    localparam logic [3:0] OFF_DAC_CTRL     = 4'd1;  // commanded current
    localparam logic [3:0] OFF_MOTOR_STATUS = 4'd2;  // enable / safety status

    //--------------------------------------
    // safety check and rt block
    //--------------------------------------
    localparam cur_t CUR_MID       = 16'h8000;
    localparam cur_t SAFETY_MARGIN = 16'h0400;  // slack on top of 2x command
    localparam int   SAFETY_HOLD   = 16;        // cycles over limit before trip
    localparam int   HOLD_W        = $clog2(SAFETY_HOLD);

    localparam int RT_WORDS = 4;  // one command word per channel

endpackage

`default_nettype wire
